// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the MIPS core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module mipsCoreTb -o mipsCoreSim

# assertion errors should not stop the run before the testbench verdict
./obj_dir/mipsCoreSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
echo "simulation finished without failure"

// ==== verification/mipsCoreChecker.sv ====
//==========================================================
// MIPS core checker, compares write-backs, stores and fetch order
//==========================================================
`timescale 1ns/10ps
`include "mips_settings.svh"

module mipsCoreChecker (
  input  logic                         clk,
  input  logic                         rst,
  input  mipsCorePkg::word_t           instrAddr,
  input  mipsCorePkg::word_t           instr,
  input  logic                         cen,
  input  logic                         wen,
  input  logic [`MIPS_DMEM_ADDR_W-1:0] dataAddr,
  input  mipsCorePkg::word_t           dataWrite,
  input  logic                         rfWriteEn,
  input  mipsCorePkg::regAddr_t        rfWriteAddr,
  input  mipsCorePkg::word_t           rfWriteData,
  output int                           valueErrors,
  output int                           flowErrors
);
  import mipsCorePkg::*;
  import mipsIsaPkg::*;

  // expected records, in program order
  regAddr_t                     wbAddrQ[$];
  word_t                        wbDataQ[$];
  logic [`MIPS_DMEM_ADDR_W-1:0] storeAddrQ[$];
  word_t                        storeDataQ[$];

  int    valueErrs = 0;
  int    flowErrs = 0;
  logic  started = 1'b0;
  word_t prevAddr;
  word_t prevInstr;

  assign valueErrors = valueErrs;
  assign flowErrors  = flowErrs;

  task automatic expectWrite(input regAddr_t addr, input word_t data);
    wbAddrQ.push_back(addr);
    wbDataQ.push_back(data);
  endtask

  task automatic expectStore(input logic [`MIPS_DMEM_ADDR_W-1:0] addr, input word_t data);
    storeAddrQ.push_back(addr);
    storeDataQ.push_back(data);
  endtask

  // records nobody consumed
  task automatic countLeftovers(output int missing);
    missing = wbAddrQ.size() + storeAddrQ.size();
    if (wbAddrQ.size() != 0) begin
      $display("%0d expected write-backs never happened", wbAddrQ.size());
    end
    if (storeAddrQ.size() != 0) begin
      $display("%0d expected stores never happened", storeAddrQ.size());
    end
  endtask

  // no jump or branch opcode, so the next fetch is pc + 4
  function automatic logic isStraightLine(input word_t insn);
    logic [5:0] op;
    logic [5:0] fn;
    op = insn[31:26];
    fn = insn[5:0];
    if (op == OP_J || op == OP_JAL || op == OP_BEQ) begin
      return 1'b0;
    end
    if (op == OP_RTYPE && fn == FN_JR) begin
      return 1'b0;
    end
    return 1'b1;
  endfunction

  //==========================================================
  // compare at the edge that ends each instruction
  //==========================================================
  always @(posedge clk) begin
    if (!rst) begin
      started = 1'b0;
    end else begin
      // fetch order
      if (!started && instrAddr !== `MIPS_RESET_PC) begin
        $display("ERROR at %0t: first fetch at %h, expected %h", $time, instrAddr,
                 `MIPS_RESET_PC);
        valueErrs++;
      end else if (started && isStraightLine(prevInstr) && instrAddr !== prevAddr + 32'd4) begin
        $display("ERROR at %0t: fetch at %h after %h, expected the next word", $time,
                 instrAddr, prevAddr);
        valueErrs++;
      end
      started   = 1'b1;
      prevAddr  = instrAddr;
      prevInstr = instr;

      // chip enable only for loads and stores
      if (cen !== !(instr[31:26] == OP_LW || instr[31:26] == OP_SW)) begin
        $display("ERROR at %0t: cen = %b for opcode %h", $time, cen, instr[31:26]);
        valueErrs++;
      end

      // register write-back
      if (rfWriteEn) begin
        if (wbAddrQ.size() == 0) begin
          $display("write-back to r%0d at %0t is beyond the expected list", rfWriteAddr, $time);
          flowErrs++;
        end else if (rfWriteAddr !== wbAddrQ[0] || rfWriteData !== wbDataQ[0]) begin
          $display("ERROR at %0t: write-back r%0d = %h, expected r%0d = %h", $time,
                   rfWriteAddr, rfWriteData, wbAddrQ[0], wbDataQ[0]);
          valueErrs++;
        end
        if (wbAddrQ.size() != 0) begin
          void'(wbAddrQ.pop_front());
          void'(wbDataQ.pop_front());
        end
      end

      // data memory store
      if (!cen && !wen) begin
        if (storeAddrQ.size() == 0) begin
          $display("store to word %h at %0t is beyond the expected list", dataAddr, $time);
          flowErrs++;
        end else if (dataAddr !== storeAddrQ[0] || dataWrite !== storeDataQ[0]) begin
          $display("ERROR at %0t: store [%h] = %h, expected [%h] = %h", $time,
                   dataAddr, dataWrite, storeAddrQ[0], storeDataQ[0]);
          valueErrs++;
        end
        if (storeAddrQ.size() != 0) begin
          void'(storeAddrQ.pop_front());
          void'(storeDataQ.pop_front());
        end
      end
    end
  end

endmodule

// ==== verification/mipsCoreTb.sv ====
//==========================================================
// MIPS core testbench, memory models, vector loading, verdict
//==========================================================
`timescale 1ns/10ps
`include "mips_settings.svh"

module mipsCoreTb;
  import mipsCorePkg::*;

  localparam int ImemWords = 64;
  localparam int DmemWords = 1 << `MIPS_DMEM_ADDR_W;
  localparam int MaxCycles = 500;

  logic                         clk;
  logic                         rst;
  word_t                        instrAddr;
  word_t                        instr;
  logic [`MIPS_DMEM_ADDR_W-1:0] dataAddr;
  word_t                        dataWrite;
  word_t                        dataRead;
  logic                         cen;
  logic                         wen;
  logic                         rfWriteEn;
  regAddr_t                     rfWriteAddr;
  word_t                        rfWriteData;
  int                           valueErrors;
  int                           flowErrors;
  int                           runErrors;
  word_t                        imem [ImemWords];
  word_t                        dmem [DmemWords];

  mipsCore mipsCore_inst (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .dataAddr(dataAddr), .dataWrite(dataWrite), .dataRead(dataRead),
    .cen(cen), .wen(wen), .rfWriteEn(rfWriteEn), .rfWriteAddr(rfWriteAddr),
    .rfWriteData(rfWriteData)
  );

  mipsCoreChecker mipsCoreChecker_inst (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .cen(cen), .wen(wen), .dataAddr(dataAddr), .dataWrite(dataWrite),
    .rfWriteEn(rfWriteEn), .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData),
    .valueErrors(valueErrors), .flowErrors(flowErrors)
  );

  bind mipsCore mipsCore_asserts mipsCore_asserts_inst (
    .clk(clk), .rst(rst), .cen(cen), .wen(wen),
    .rfWriteEn(rfWriteEn), .rfWriteAddr(rfWriteAddr)
  );

  // 8 ns period
  always #4 clk = ~clk;

  //==========================================================
  // memory models, both answer within the cycle
  //==========================================================
  assign instr    = imem[instrAddr[7:2]];
  assign dataRead = dmem[dataAddr];

  // word i holds i * 0x20000101 after reset, so word 4 is negative
  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < DmemWords; i++) begin
        dmem[i] <= i * 32'h2000_0101;
      end
    end else if (!cen && !wen) begin
      dmem[dataAddr] <= dataWrite;
    end
  end

  // I, W and S records from the vector file
  task automatic loadVectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] a;
    logic [31:0] d;
    fd = $fopen("verification/mipsCore_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      runErrors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
        if (n != 2) begin
          $display("unreadable vector line: %s", line);
          runErrors++;
        end else if (line[0] == "I") begin
          imem[a[7:2]] = d;
        end else if (line[0] == "W") begin
          mipsCoreChecker_inst.expectWrite(a[4:0], d);
        end else if (line[0] == "S") begin
          mipsCoreChecker_inst.expectStore(a[`MIPS_DMEM_ADDR_W-1:0], d);
        end else begin
          $display("unknown tag in vector line: %s", line);
          runErrors++;
        end
      end
    end
    $fclose(fd);
  endtask

  // program ends on a jump to itself
  task automatic waitForSelfJump();
    word_t lastAddr;
    int    cycles;
    lastAddr = '1;
    cycles   = 0;
    while (cycles < MaxCycles) begin
      @(negedge clk);
      if (instrAddr == lastAddr) begin
        break;
      end
      lastAddr = instrAddr;
      cycles++;
    end
    if (cycles >= MaxCycles) begin
      $display("timeout, the program never reached its closing self-jump");
      runErrors++;
    end
  endtask

  initial begin
    int leftover;
    int assertFails;
    int total;
    clk       = 1'b0;
    rst       = 1'b0;
    runErrors = 0;
    // unknown opcode 0x3f everywhere the program does not reach
    for (int i = 0; i < ImemWords; i++) begin
      imem[i] = 32'hfc00_0000 | i;
    end
    loadVectors();
    repeat (2) @(negedge clk);
    rst = 1'b1;
    waitForSelfJump();
    mipsCoreChecker_inst.countLeftovers(leftover);
    assertFails = mipsCore_inst.mipsCore_asserts_inst.failCount;
    total = valueErrors + flowErrors + leftover + runErrors + assertFails;
    $display("errors: value %0d, flow %0d, missing %0d, run %0d, assertion %0d",
             valueErrors, flowErrors, leftover, runErrors, assertFails);
    if (total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verification/mipsCore_asserts.sv ====
//==========================================================
// bound port rules of the MIPS core
//==========================================================
`timescale 1ns/10ps

module mipsCore_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  cen,
  input logic                  wen,
  input logic                  rfWriteEn,
  input mipsCorePkg::regAddr_t rfWriteAddr
);
  import mipsCorePkg::*;

  // failures seen so far, read by the testbench at the end
  int failCount = 0;

  // a write strobe needs the chip enable with it
  wenNeedsCen: assert property (@(posedge clk) cen |-> wen)
    else begin
      failCount++;
      $error("wen low while cen is high");
    end

  // r0 targets never leave the core as a write-back
  noZeroWrite: assert property (@(posedge clk) rfWriteEn |-> (rfWriteAddr != '0))
    else begin
      failCount++;
      $error("write-back to register zero");
    end

  // memory and register file idle in reset
  quietInReset: assert property (@(posedge clk) !rst |-> (cen && !rfWriteEn))
    else begin
      failCount++;
      $error("core active while reset is low");
    end

endmodule

// ==== verification/mipsCore_vectors.txt ====
# I: byte address, program word | W: register, value | S: data word address, value
# W and S records are listed in program order
I 00 8c010004 # lw  r1, 4(r0)
I 04 8c020008 # lw  r2, 8(r0)
I 08 8c030010 # lw  r3, 16(r0)
I 0c 00222020 # add r4, r1, r2
I 10 00412822 # sub r5, r2, r1
I 14 00823024 # and r6, r4, r2
I 18 00233825 # or  r7, r1, r3
I 1c 0061402a # slt r8, r3, r1
I 20 0023482a # slt r9, r1, r3
I 24 00220020 # add r0, r1, r2
I 28 ac070028 # sw  r7, 40(r0)
I 2c 8c0a0028 # lw  r10, 40(r0)
I 30 10a10001 # beq r5, r1, +1 (taken)
I 34 00215820 # add r11, r1, r1 (skipped)
I 38 10220001 # beq r1, r2, +1 (not taken)
I 3c 00226025 # or  r12, r1, r2
I 40 08000012 # j   0x48
I 44 00216820 # add r13, r1, r1 (skipped)
I 48 0c000016 # jal 0x58
I 4c 00216820 # add r13, r1, r1 (skipped)
I 50 00617022 # sub r14, r3, r1
I 54 08000015 # j   0x54
I 58 00677824 # and r15, r3, r7
I 5c 03e00008 # jr  r31
W 01 20000101
W 02 40000202
W 03 80000404
W 04 60000303
W 05 20000101
W 06 40000202
W 07 a0000505
W 08 00000001
W 09 00000000
S 0a a0000505
W 0a a0000505
W 0c 60000303
W 1f 00000050
W 0f 80000404
W 0e 60000303

// ==== verilog.f ====
+incdir+verilog
verilog/mipsIsaPkg.sv
verilog/mipsCorePkg.sv
verilog/mainControl.sv
verilog/aluUnit.sv
verilog/registerFile.sv
verilog/pcUnit.sv
verilog/mipsCore.sv
verification/mipsCoreChecker.sv
verification/mipsCore_asserts.sv
verification/mipsCoreTb.sv

// ==== verilog/aluUnit.sv ====
//==========================================================
// ALU operation select and arithmetic/logic unit
// computes add, sub, and, or, signed slt and a zero flag
//==========================================================
`timescale 1ns/10ps

module aluUnit (
  input  mipsCorePkg::aluClass_t aluClass,
  input  mipsIsaPkg::funct_t     funct,
  input  mipsCorePkg::word_t     a,
  input  mipsCorePkg::word_t     b,
  output mipsCorePkg::word_t     result,
  output logic                   zero
);
  import mipsIsaPkg::*;
  import mipsCorePkg::*;

  aluOp_t op;

  //==========================================================
  // operation select
  //==========================================================
  always_comb begin
    case (aluClass)
      CLS_MEM_ADDR: op = ALU_ADD;
      CLS_BRANCH:   op = ALU_SUB;
      default: begin
        // R-type follows the function field
        case (funct)
          FN_ADD:  op = ALU_ADD;
          FN_SUB:  op = ALU_SUB;
          FN_AND:  op = ALU_AND;
          FN_OR:   op = ALU_OR;
          FN_SLT:  op = ALU_SLT;
          default: op = ALU_NONE;
        endcase
      end
    endcase
  end

  //==========================================================
  // datapath
  //==========================================================
  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // signed compare, one in bit 0
      ALU_SLT: result = {31'd0, ($signed(a) < $signed(b))};
      default: result = '0;
    endcase
  end

  // beq takes the branch on equal operands
  assign zero = (result == '0);

endmodule

// ==== verilog/mainControl.sv ====
//==========================================================
// main decoder, opcode and funct to datapath control levels
//==========================================================
`timescale 1ns/10ps

module mainControl (
  input  mipsIsaPkg::opcode_t    opcode,
  input  mipsIsaPkg::funct_t     funct,
  output logic                   regDst,
  output logic                   aluSrc,
  output logic                   memToReg,
  output logic                   regWrite,
  output logic                   memWrite,
  output logic                   branch,
  output logic                   jump,
  output logic                   link,
  output logic                   regJump,
  output mipsCorePkg::aluClass_t aluClass
);
  import mipsIsaPkg::*;
  import mipsCorePkg::*;

  always_comb begin
    // all idle by default, so unknown opcodes do nothing
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    regJump  = 1'b0;
    aluClass = CLS_MEM_ADDR;
    case (opcode)
      OP_RTYPE: begin
        regDst   = 1'b1;
        aluClass = CLS_FUNCT;
        // jr only redirects, it writes no register
        if (funct == FN_JR) begin
          regJump = 1'b1;
        end else begin
          regWrite = 1'b1;
        end
      end
      OP_LW: begin
        // address = rs + offset
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      OP_BEQ: begin
        // compare by subtract, zero flag decides
        branch   = 1'b1;
        aluClass = CLS_BRANCH;
      end
      OP_J: begin
        jump = 1'b1;
      end
      OP_JAL: begin
        // link address goes to r31
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        regWrite = 1'b0;
      end
    endcase
  end

endmodule

// ==== verilog/mipsCore.sv ====
//==========================================================
// single-cycle MIPS subset core, top level
// control, datapath and the memory and observation ports
//==========================================================
`timescale 1ns/10ps
`include "mips_settings.svh"

module mipsCore (
  input  logic                         clk,
  input  logic                         rst,
  output mipsCorePkg::word_t           instrAddr,
  input  mipsCorePkg::word_t           instr,
  output logic [`MIPS_DMEM_ADDR_W-1:0] dataAddr,
  output mipsCorePkg::word_t           dataWrite,
  input  mipsCorePkg::word_t           dataRead,
  output logic                         cen,
  output logic                         wen,
  output logic                         rfWriteEn,
  output mipsCorePkg::regAddr_t        rfWriteAddr,
  output mipsCorePkg::word_t           rfWriteData
);
  import mipsCorePkg::*;
  import mipsIsaPkg::*;

  opcode_t   opcode;
  funct_t    funct;
  regAddr_t  rs;
  regAddr_t  rt;
  regAddr_t  rd;
  word_t     immExt;
  logic      regDst, aluSrc, memToReg, regWrite, memWrite;
  logic      branch, jump, link, regJump;
  aluClass_t aluClass;
  word_t     rsVal, rtVal, aluB, aluResult, pc, linkAddr;
  logic      zero;

  //==========================================================
  // instruction fields
  //==========================================================
  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign immExt = {{16{instr[15]}}, instr[15:0]};

  mainControl mainControl_inst (
    .opcode(opcode), .funct(funct), .regDst(regDst), .aluSrc(aluSrc),
    .memToReg(memToReg), .regWrite(regWrite), .memWrite(memWrite),
    .branch(branch), .jump(jump), .link(link), .regJump(regJump),
    .aluClass(aluClass)
  );

  registerFile registerFile_inst (
    .clk(clk), .rst(rst), .writeEn(rfWriteEn), .readAddrA(rs), .readAddrB(rt),
    .writeAddr(rfWriteAddr), .writeData(rfWriteData),
    .readDataA(rsVal), .readDataB(rtVal)
  );

  // second operand, register or offset
  assign aluB = aluSrc ? immExt : rtVal;

  aluUnit aluUnit_inst (
    .aluClass(aluClass), .funct(funct), .a(rsVal), .b(aluB),
    .result(aluResult), .zero(zero)
  );

  pcUnit pcUnit_inst (
    .clk(clk), .rst(rst), .immExt(immExt), .jumpField(instr[25:0]),
    .regTarget(rsVal), .takeBranch(branch & zero), .jump(jump),
    .regJump(regJump), .pc(pc), .linkAddr(linkAddr)
  );

  //==========================================================
  // write-back and memory ports
  //==========================================================
  // jal goes to r31, R-type to rd, lw to rt
  assign rfWriteAddr = link ? 5'd31 : (regDst ? rd : rt);
  assign rfWriteData = link ? linkAddr : (memToReg ? dataRead : aluResult);
  // quiet during reset, r0 targets never show as a write-back
  assign rfWriteEn = regWrite & rst & (rfWriteAddr != '0);

  assign instrAddr = pc;
  // word address, byte offset dropped
  assign dataAddr  = aluResult[`MIPS_DMEM_ADDR_W+1:2];
  assign dataWrite = rtVal;
  // strobes are active low, idle during reset
  assign cen = ~((memToReg | memWrite) & rst);
  assign wen = ~(memWrite & rst);

endmodule

// ==== verilog/mipsCorePkg.sv ====
//==========================================================
// datapath types of the single-cycle MIPS core
// word, register number and ALU control encodings
//==========================================================
package mipsCorePkg;

  // datapath word
  typedef logic [31:0] word_t;

  // register file index
  typedef logic [4:0] regAddr_t;

  //==========================================================
  // ALU operations
  //==========================================================
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    // unknown funct, result forced to zero
    ALU_NONE
  } aluOp_t;

  // what the ALU select follows
  // mem address forces add, branch forces sub
  typedef enum logic [1:0] {
    CLS_MEM_ADDR,
    CLS_BRANCH,
    CLS_FUNCT
  } aluClass_t;

endpackage

// ==== verilog/mipsIsaPkg.sv ====
//==========================================================
// MIPS subset instruction encodings
// opcode and R-type function codes
//==========================================================
package mipsIsaPkg;

  //==========================================================
  // primary opcode, instr[31:26]
  //==========================================================
  typedef enum logic [5:0] {
    // all R-type ops share opcode zero
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_t;

  //==========================================================
  // R-type function field, instr[5:0]
  //==========================================================
  typedef enum logic [5:0] {
    // register jump, target taken from rs
    FN_JR  = 6'h08,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    // signed compare
    FN_SLT = 6'h2a
  } funct_t;

endpackage

// ==== verilog/mips_settings.svh ====
//==========================================================
// build settings for the single-cycle MIPS core
// data memory depth and the reset fetch address
//==========================================================
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// word address width on the data memory port
// 7 bits gives 128 words of data memory
`define MIPS_DMEM_ADDR_W 7

// address of the first fetch after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== verilog/pcUnit.sv ====
//==========================================================
// program counter and next-address selection
// sequential, branch, jump and register-jump targets
//==========================================================
`timescale 1ns/10ps
`include "mips_settings.svh"

module pcUnit (
  input  logic               clk,
  input  logic               rst,
  input  mipsCorePkg::word_t immExt,
  input  logic [25:0]        jumpField,
  input  mipsCorePkg::word_t regTarget,
  input  logic               takeBranch,
  input  logic               jump,
  input  logic               regJump,
  output mipsCorePkg::word_t pc,
  output mipsCorePkg::word_t linkAddr
);
  import mipsCorePkg::*;

  word_t pcPlus4;
  word_t branchTarget;
  word_t jumpTarget;
  word_t pcNext;

  //==========================================================
  // candidate targets
  //==========================================================
  assign pcPlus4 = pc + 32'd4;
  // word offset, relative to the next instruction
  assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
  // region bits kept from pc + 4
  assign jumpTarget = {pcPlus4[31:28], jumpField, 2'b00};

  // priority jump, branch, jr, then sequential
  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (takeBranch) begin
      pcNext = branchTarget;
    end else if (regJump) begin
      pcNext = regTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

  // jal return address, two words past the jal
  assign linkAddr = pc + 32'd8;

endmodule

// ==== verilog/registerFile.sv ====
//==========================================================
// 32 x 32 register file, two read ports, one write port
//==========================================================
`timescale 1ns/10ps

module registerFile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  writeEn,
  input  mipsCorePkg::regAddr_t readAddrA,
  input  mipsCorePkg::regAddr_t readAddrB,
  input  mipsCorePkg::regAddr_t writeAddr,
  input  mipsCorePkg::word_t    writeData,
  output mipsCorePkg::word_t    readDataA,
  output mipsCorePkg::word_t    readDataB
);
  import mipsCorePkg::*;

  word_t regs [32];

  // whole file clears on reset
  // writes to r0 are dropped
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  //==========================================================
  // combinational reads, r0 hardwired to zero
  //==========================================================
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule
